// ==== src/dbf_defines.svh ====
// Widths, limits and thresholds of the luma deblocking engine, included by RTL and testbench
`ifndef DBF_DEFINES_SVH
`define DBF_DEFINES_SVH

// ********************************************************************
// Edge geometry
// ********************************************************************
`define DBF_PIX_W 8
`define DBF_LINES 4
`define DBF_TAPS 8
`define DBF_LINE_W (`DBF_TAPS * `DBF_PIX_W)
`define DBF_EDGE_W (`DBF_LINES * `DBF_LINE_W)

// ********************************************************************
// Quantizer and side information
// ********************************************************************
`define DBF_QP_W 6
`define DBF_QP_MAX 51
`define DBF_MV_W 8
`define DBF_BS_W 3
`define DBF_TC_W 5

// Quarter-pel difference that already counts as a motion edge
`define DBF_MV_THRESH 4

// bs value that selects the strong filter
`define DBF_BS_STRONG 4

// First table index with a non-zero entry
`define DBF_ALPHA_QP0 16
`define DBF_TC0_QP0 17

`endif

// ==== src/dbf_pkg.sv ====
// Shared types, handshake states and the standard H.264 luma threshold tables
`include "dbf_defines.svh"

package dbf_pkg;

	// ********************************************************************
	// Vector types
	// ********************************************************************
	typedef logic [`DBF_PIX_W-1:0]    pix_t;
	// Line k in bits 64k upward, p3 in the lowest byte of a line
	typedef logic [`DBF_EDGE_W-1:0]   edge_px_t;
	typedef logic [`DBF_QP_W-1:0]     qp_t;
	// y component in the upper byte, x in the lower
	typedef logic [2*`DBF_MV_W-1:0]   mv_t;
	typedef logic [`DBF_BS_W-1:0]     bs_t;
	typedef logic [`DBF_PIX_W-1:0]    thr_t;
	typedef logic [`DBF_TC_W-1:0]     tc_t;

	// Four-phase handshake, one per stage
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,
		HS_DONE
	} hs_state_t;

	// ********************************************************************
	// Standard tables
	// ********************************************************************
	// Alpha for index 16..51
	localparam thr_t ALPHA_TAB [0:35] = '{
		4, 4, 5, 6, 7, 8, 9, 10, 12, 13,
		15, 17, 20, 22, 25, 28, 32, 36, 40, 45,
		50, 56, 63, 71, 80, 90, 101, 113, 127, 144,
		162, 182, 203, 226, 255, 255
	};

	// Beta for index 16..51
	localparam thr_t BETA_TAB [0:35] = '{
		2, 2, 2, 3, 3, 3, 3, 4, 4, 4,
		6, 6, 7, 7, 8, 8, 9, 9, 10, 10,
		11, 11, 12, 12, 13, 13, 14, 14, 15, 15,
		16, 16, 17, 17, 18, 18
	};

	// tc0 for index 17..51, one table per bs
	localparam tc_t TC0_BS1_TAB [0:34] = '{
		0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2,
		2, 2, 3, 3, 3, 4, 4, 4, 5, 6, 6, 7, 8, 9, 10, 11, 13
	};

	localparam tc_t TC0_BS2_TAB [0:34] = '{
		0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 2,
		3, 3, 3, 4, 4, 5, 5, 6, 7, 8, 8, 10, 11, 12, 13, 15, 17
	};

	localparam tc_t TC0_BS3_TAB [0:34] = '{
		1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 2, 3, 3, 3, 4,
		4, 4, 5, 6, 6, 7, 8, 9, 10, 11, 13, 14, 16, 18, 20, 23, 25
	};

	// QP above the legal range reads the last row
	function automatic qp_t clamp_qp(input qp_t qp);
		return (qp > `DBF_QP_MAX) ? qp_t'(`DBF_QP_MAX) : qp;
	endfunction

	function automatic thr_t alpha_of(input qp_t qp);
		qp_t idx;
		idx = clamp_qp(qp);
		if (idx < `DBF_ALPHA_QP0) begin
			return '0;
		end
		return ALPHA_TAB[idx - `DBF_ALPHA_QP0];
	endfunction

	function automatic thr_t beta_of(input qp_t qp);
		qp_t idx;
		idx = clamp_qp(qp);
		if (idx < `DBF_ALPHA_QP0) begin
			return '0;
		end
		return BETA_TAB[idx - `DBF_ALPHA_QP0];
	endfunction

	// Only bs 1..3 have a tc0, everything else gives 0
	function automatic tc_t tc0_of(input qp_t qp, input bs_t bs);
		qp_t idx;
		int  row;
		idx = clamp_qp(qp);
		if (idx < `DBF_TC0_QP0) begin
			return '0;
		end
		row = idx - `DBF_TC0_QP0;
		case (bs)
			3'd1: return TC0_BS1_TAB[row];
			3'd2: return TC0_BS2_TAB[row];
			3'd3: return TC0_BS3_TAB[row];
			default: return '0;
		endcase
	endfunction

endpackage

// ==== src/dbf_bs_decode.sv ====
// Decode stage that accepts edge jobs, derives bs and looks up alpha, beta and tc0
`timescale 1ns/1ps
`include "dbf_defines.svh"

module dbf_bs_decode (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_req_i,
	output logic               in_ack_o,
	input  dbf_pkg::qp_t       qp_i,
	input  logic               intra_p_i,
	input  logic               intra_q_i,
	input  logic               nz_p_i,
	input  logic               nz_q_i,
	input  dbf_pkg::mv_t       mv_p_i,
	input  dbf_pkg::mv_t       mv_q_i,
	input  logic               mb_edge_i,
	input  dbf_pkg::edge_px_t  px_i,
	output logic               dec_req_o,
	input  logic               dec_ack_i,
	output dbf_pkg::bs_t       bs_o,
	output dbf_pkg::thr_t      alpha_o,
	output dbf_pkg::thr_t      beta_o,
	output dbf_pkg::tc_t       tc0_o,
	output dbf_pkg::edge_px_t  px_o
);

	dbf_pkg::hs_state_t        state;
	dbf_pkg::bs_t              bs_next;
	logic signed [`DBF_MV_W:0] dx;
	logic signed [`DBF_MV_W:0] dy;
	logic                      mv_big;
	logic                      take;

	// ********************************************************************
	// Boundary strength
	// ********************************************************************
	// Sign-extended differences of the x and y components
	assign dx = $signed({mv_p_i[`DBF_MV_W-1], mv_p_i[`DBF_MV_W-1:0]})
		- $signed({mv_q_i[`DBF_MV_W-1], mv_q_i[`DBF_MV_W-1:0]});
	assign dy = $signed({mv_p_i[2*`DBF_MV_W-1], mv_p_i[2*`DBF_MV_W-1 -: `DBF_MV_W]})
		- $signed({mv_q_i[2*`DBF_MV_W-1], mv_q_i[2*`DBF_MV_W-1 -: `DBF_MV_W]});

	assign mv_big = (dx >= `DBF_MV_THRESH) || (dx <= -`DBF_MV_THRESH)
		|| (dy >= `DBF_MV_THRESH) || (dy <= -`DBF_MV_THRESH);

	always_comb begin
		if ((intra_p_i || intra_q_i) && mb_edge_i) begin
			bs_next = 3'd4;
		end else if (intra_p_i || intra_q_i) begin
			bs_next = 3'd3;
		end else if (nz_p_i || nz_q_i) begin
			bs_next = 3'd2;
		end else if (mv_big) begin
			bs_next = 3'd1;
		end else begin
			bs_next = 3'd0;
		end
	end

	// ********************************************************************
	// Handshake
	// ********************************************************************
	assign take = (state == dbf_pkg::HS_IDLE) && in_req_i && !in_ack_o;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= dbf_pkg::HS_IDLE;
			in_ack_o  <= 1'b0;
			dec_req_o <= 1'b0;
		end else begin
			// Input ack follows the producer's req down
			if (in_ack_o && !in_req_i) begin
				in_ack_o <= 1'b0;
			end
			case (state)
				dbf_pkg::HS_IDLE: begin
					if (take) begin
						in_ack_o <= 1'b1;
						state    <= dbf_pkg::HS_REQ;
					end
				end
				dbf_pkg::HS_REQ: begin
					if (!dec_req_o) begin
						dec_req_o <= 1'b1;
					end else if (dec_ack_i) begin
						dec_req_o <= 1'b0;
						state     <= dbf_pkg::HS_DONE;
					end
				end
				dbf_pkg::HS_DONE: begin
					if (!dec_ack_i) begin
						state <= dbf_pkg::HS_IDLE;
					end
				end
				default: state <= dbf_pkg::HS_IDLE;
			endcase
		end
	end

	// Job results, held until execute has taken them
	always_ff @(posedge clk) begin
		if (take) begin
			bs_o    <= bs_next;
			alpha_o <= dbf_pkg::alpha_of(qp_i);
			beta_o  <= dbf_pkg::beta_of(qp_i);
			tc0_o   <= dbf_pkg::tc0_of(qp_i, bs_next);
			px_o    <= px_i;
		end
	end

	a_bs_range: assert property (@(posedge clk) disable iff (!rst)
		dec_req_o |-> (bs_o <= `DBF_BS_STRONG));

	a_px_hold: assert property (@(posedge clk) disable iff (!rst)
		dec_req_o |=> !dec_req_o || $stable(px_o));

endmodule

// ==== src/dbf_edge_filter.sv ====
// Execute stage that applies the H.264 luma edge filter to all four lines of a job
`timescale 1ns/1ps
`include "dbf_defines.svh"

module dbf_edge_filter (
	input  logic               clk,
	input  logic               rst,
	input  logic               dec_req_i,
	output logic               dec_ack_o,
	input  dbf_pkg::bs_t       bs_i,
	input  dbf_pkg::thr_t      alpha_i,
	input  dbf_pkg::thr_t      beta_i,
	input  dbf_pkg::tc_t       tc0_i,
	input  dbf_pkg::edge_px_t  px_i,
	output logic               exe_req_o,
	input  logic               exe_ack_i,
	output dbf_pkg::edge_px_t  px_o,
	output dbf_pkg::bs_t       bs_o
);

	typedef logic signed [11:0] sval_t;
	typedef logic [`DBF_LINE_W-1:0] line_t;

	// Sample positions within one line
	localparam int IDX_P3 = 0;
	localparam int IDX_P2 = 1;
	localparam int IDX_P1 = 2;
	localparam int IDX_P0 = 3;
	localparam int IDX_Q0 = 4;
	localparam int IDX_Q1 = 5;
	localparam int IDX_Q2 = 6;
	localparam int IDX_Q3 = 7;

	dbf_pkg::hs_state_t state;
	dbf_pkg::edge_px_t  px_filt;
	logic               take;

	// ********************************************************************
	// Arithmetic helpers
	// ********************************************************************
	function automatic sval_t tap(input line_t line, input int idx);
		return sval_t'(line[idx*`DBF_PIX_W +: `DBF_PIX_W]);
	endfunction

	function automatic sval_t absv(input sval_t v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic sval_t clip3(input sval_t lo, input sval_t hi, input sval_t v);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic dbf_pkg::pix_t clip1(input sval_t v);
		return (v < 0) ? '0 : ((v > 255) ? 8'd255 : v[`DBF_PIX_W-1:0]);
	endfunction

	// ********************************************************************
	// One line across the edge
	// ********************************************************************
	function automatic line_t filter_line(
		input line_t         line,
		input dbf_pkg::bs_t  bs,
		input dbf_pkg::thr_t alpha,
		input dbf_pkg::thr_t beta,
		input dbf_pkg::tc_t  tc0
	);
		sval_t p3, p2, p1, p0, q0, q1, q2, q3;
		sval_t sa, sb, stc0, tc, delta, mid;
		logic  ap_ok, aq_ok;
		line_t res;
		p3 = tap(line, IDX_P3);
		p2 = tap(line, IDX_P2);
		p1 = tap(line, IDX_P1);
		p0 = tap(line, IDX_P0);
		q0 = tap(line, IDX_Q0);
		q1 = tap(line, IDX_Q1);
		q2 = tap(line, IDX_Q2);
		q3 = tap(line, IDX_Q3);
		sa = sval_t'(alpha);
		sb = sval_t'(beta);
		stc0 = sval_t'(tc0);
		res = line;
		// Line stays as it is unless bs and all gradients allow filtering
		if (bs == '0 || absv(p0 - q0) >= sa || absv(p1 - p0) >= sb || absv(q1 - q0) >= sb) begin
			return line;
		end
		ap_ok = absv(p2 - p0) < sb;
		aq_ok = absv(q2 - q0) < sb;
		if (bs < `DBF_BS_STRONG) begin
			// Normal filter
			tc = stc0 + sval_t'(ap_ok) + sval_t'(aq_ok);
			delta = clip3(-tc, tc, ((((q0 - p0) <<< 2) + (p1 - q1) + 4) >>> 3));
			mid = (p0 + q0 + 1) >>> 1;
			res[IDX_P0*`DBF_PIX_W +: `DBF_PIX_W] = clip1(p0 + delta);
			res[IDX_Q0*`DBF_PIX_W +: `DBF_PIX_W] = clip1(q0 - delta);
			if (ap_ok) begin
				res[IDX_P1*`DBF_PIX_W +: `DBF_PIX_W] =
					clip1(p1 + clip3(-stc0, stc0, (p2 + mid - (p1 <<< 1)) >>> 1));
			end
			if (aq_ok) begin
				res[IDX_Q1*`DBF_PIX_W +: `DBF_PIX_W] =
					clip1(q1 + clip3(-stc0, stc0, (q2 + mid - (q1 <<< 1)) >>> 1));
			end
		end else begin
			// Strong filter, each side decides on its own
			if (ap_ok && absv(p0 - q0) < ((sa >>> 2) + 2)) begin
				res[IDX_P0*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((p2 + 2*p1 + 2*p0 + 2*q0 + q1 + 4) >>> 3);
				res[IDX_P1*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((p2 + p1 + p0 + q0 + 2) >>> 2);
				res[IDX_P2*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((2*p3 + 3*p2 + p1 + p0 + q0 + 4) >>> 3);
			end else begin
				res[IDX_P0*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((2*p1 + p0 + q1 + 2) >>> 2);
			end
			if (aq_ok && absv(p0 - q0) < ((sa >>> 2) + 2)) begin
				res[IDX_Q0*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((p1 + 2*p0 + 2*q0 + 2*q1 + q2 + 4) >>> 3);
				res[IDX_Q1*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((p0 + q0 + q1 + q2 + 2) >>> 2);
				res[IDX_Q2*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((2*q3 + 3*q2 + q1 + q0 + p0 + 4) >>> 3);
			end else begin
				res[IDX_Q0*`DBF_PIX_W +: `DBF_PIX_W] =
					dbf_pkg::pix_t'((2*q1 + q0 + p1 + 2) >>> 2);
			end
		end
		return res;
	endfunction

	// All four lines in parallel
	always_comb begin
		for (int k = 0; k < `DBF_LINES; k++) begin
			px_filt[k*`DBF_LINE_W +: `DBF_LINE_W] =
				filter_line(px_i[k*`DBF_LINE_W +: `DBF_LINE_W], bs_i, alpha_i, beta_i, tc0_i);
		end
	end

	// ********************************************************************
	// Handshake
	// ********************************************************************
	assign take = (state == dbf_pkg::HS_IDLE) && dec_req_i && !dec_ack_o;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= dbf_pkg::HS_IDLE;
			dec_ack_o <= 1'b0;
			exe_req_o <= 1'b0;
		end else begin
			if (dec_ack_o && !dec_req_i) begin
				dec_ack_o <= 1'b0;
			end
			case (state)
				dbf_pkg::HS_IDLE: begin
					if (take) begin
						dec_ack_o <= 1'b1;
						state     <= dbf_pkg::HS_REQ;
					end
				end
				dbf_pkg::HS_REQ: begin
					if (!exe_req_o) begin
						exe_req_o <= 1'b1;
					end else if (exe_ack_i) begin
						exe_req_o <= 1'b0;
						state     <= dbf_pkg::HS_DONE;
					end
				end
				dbf_pkg::HS_DONE: begin
					if (!exe_ack_i) begin
						state <= dbf_pkg::HS_IDLE;
					end
				end
				default: state <= dbf_pkg::HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			px_o <= px_filt;
			bs_o <= bs_i;
		end
	end

	// Result stage must have finished the previous item
	a_req_after_ack: assert property (@(posedge clk) disable iff (!rst)
		$rose(exe_req_o) |-> !exe_ack_i);

endmodule

// ==== src/dbf_result_hold.sv ====
// Result stage that holds filtered edges and offers them to the consumer on req/ack
`timescale 1ns/1ps

module dbf_result_hold (
	input  logic               clk,
	input  logic               rst,
	input  logic               exe_req_i,
	output logic               exe_ack_o,
	input  dbf_pkg::edge_px_t  px_i,
	input  dbf_pkg::bs_t       bs_i,
	output logic               out_req_o,
	input  logic               out_ack_i,
	output dbf_pkg::edge_px_t  out_px_o,
	output dbf_pkg::bs_t       out_bs_o
);

	dbf_pkg::hs_state_t state;
	logic               take;

	// Only an empty stage accepts the next result
	assign take = (state == dbf_pkg::HS_IDLE) && exe_req_i && !exe_ack_o;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= dbf_pkg::HS_IDLE;
			exe_ack_o <= 1'b0;
			out_req_o <= 1'b0;
		end else begin
			if (exe_ack_o && !exe_req_i) begin
				exe_ack_o <= 1'b0;
			end
			case (state)
				dbf_pkg::HS_IDLE: begin
					if (take) begin
						exe_ack_o <= 1'b1;
						state     <= dbf_pkg::HS_REQ;
					end
				end
				dbf_pkg::HS_REQ: begin
					if (!out_req_o) begin
						out_req_o <= 1'b1;
					end else if (out_ack_i) begin
						out_req_o <= 1'b0;
						state     <= dbf_pkg::HS_DONE;
					end
				end
				// Wait for the consumer to release ack
				dbf_pkg::HS_DONE: begin
					if (!out_ack_i) begin
						state <= dbf_pkg::HS_IDLE;
					end
				end
				default: state <= dbf_pkg::HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_px_o <= px_i;
			out_bs_o <= bs_i;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst)
		out_req_o && !out_ack_i |=> out_req_o && $stable(out_px_o) && $stable(out_bs_o));

endmodule

// ==== src/dbf_top.sv ====
// Top level of the luma deblocking edge engine, chaining decode, execute and result stages
`timescale 1ns/1ps

module dbf_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_req_i,
	output logic               in_ack_o,
	input  dbf_pkg::qp_t       qp_i,
	input  logic               intra_p_i,
	input  logic               intra_q_i,
	input  logic               nz_p_i,
	input  logic               nz_q_i,
	input  dbf_pkg::mv_t       mv_p_i,
	input  dbf_pkg::mv_t       mv_q_i,
	input  logic               mb_edge_i,
	input  dbf_pkg::edge_px_t  px_i,
	output logic               out_req_o,
	input  logic               out_ack_i,
	output dbf_pkg::edge_px_t  out_px_o,
	output dbf_pkg::bs_t       out_bs_o
);

	// ********************************************************************
	// Stage links
	// ********************************************************************
	logic               dec_req;
	logic               dec_ack;
	dbf_pkg::bs_t       dec_bs;
	dbf_pkg::thr_t      dec_alpha;
	dbf_pkg::thr_t      dec_beta;
	dbf_pkg::tc_t       dec_tc0;
	dbf_pkg::edge_px_t  dec_px;

	logic               exe_req;
	logic               exe_ack;
	dbf_pkg::edge_px_t  exe_px;
	dbf_pkg::bs_t       exe_bs;

	dbf_bs_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.in_req_i  (in_req_i),
		.in_ack_o  (in_ack_o),
		.qp_i      (qp_i),
		.intra_p_i (intra_p_i),
		.intra_q_i (intra_q_i),
		.nz_p_i    (nz_p_i),
		.nz_q_i    (nz_q_i),
		.mv_p_i    (mv_p_i),
		.mv_q_i    (mv_q_i),
		.mb_edge_i (mb_edge_i),
		.px_i      (px_i),
		.dec_req_o (dec_req),
		.dec_ack_i (dec_ack),
		.bs_o      (dec_bs),
		.alpha_o   (dec_alpha),
		.beta_o    (dec_beta),
		.tc0_o     (dec_tc0),
		.px_o      (dec_px)
	);

	dbf_edge_filter u_filter (
		.clk       (clk),
		.rst       (rst),
		.dec_req_i (dec_req),
		.dec_ack_o (dec_ack),
		.bs_i      (dec_bs),
		.alpha_i   (dec_alpha),
		.beta_i    (dec_beta),
		.tc0_i     (dec_tc0),
		.px_i      (dec_px),
		.exe_req_o (exe_req),
		.exe_ack_i (exe_ack),
		.px_o      (exe_px),
		.bs_o      (exe_bs)
	);

	dbf_result_hold u_result (
		.clk       (clk),
		.rst       (rst),
		.exe_req_i (exe_req),
		.exe_ack_o (exe_ack),
		.px_i      (exe_px),
		.bs_i      (exe_bs),
		.out_req_o (out_req_o),
		.out_ack_i (out_ack_i),
		.out_px_o  (out_px_o),
		.out_bs_o  (out_bs_o)
	);

endmodule

// ==== sim/dbf_tb.sv ====
// Directed testbench for dbf_top; runs bs, filter and back-pressure jobs against a reference model
`timescale 1ns/1ps
`include "dbf_defines.svh"

module dbf_tb;

	localparam int CLK_PERIOD = 40;
	localparam int HS_TIMEOUT = 64;
	localparam int NUM_JOBS = 36;
	// Twenty cycles per job, plus reset and the back-pressure window
	localparam int WATCHDOG_CYCLES = NUM_JOBS * 20 + 200;
	localparam int PW = `DBF_PIX_W;
	localparam int LW = `DBF_LINE_W;
	localparam int MW = `DBF_MV_W;

	logic              clk;
	logic              rst;
	logic              in_req_i;
	logic              in_ack_o;
	dbf_pkg::qp_t      qp_i;
	logic              intra_p_i;
	logic              intra_q_i;
	logic              nz_p_i;
	logic              nz_q_i;
	dbf_pkg::mv_t      mv_p_i;
	dbf_pkg::mv_t      mv_q_i;
	logic              mb_edge_i;
	dbf_pkg::edge_px_t px_i;
	logic              out_req_o;
	logic              out_ack_i;
	dbf_pkg::edge_px_t out_px_o;
	dbf_pkg::bs_t      out_bs_o;

	dbf_pkg::edge_px_t exp_px_q[$];
	dbf_pkg::bs_t      exp_bs_q[$];
	logic [31:0]       lcg_state;
	int                px_errors;
	int                bs_errors;
	int                thr_errors;
	int                proto_errors;

	dbf_top dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ********************************************************************
	// Checks and random numbers
	// ********************************************************************
	task automatic check_px(input dbf_pkg::edge_px_t got, input dbf_pkg::edge_px_t exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			px_errors++;
		end
	endtask

	task automatic check_bs(input dbf_pkg::bs_t got, input dbf_pkg::bs_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
			bs_errors++;
		end
	endtask

	task automatic check_thr(input dbf_pkg::thr_t got, input dbf_pkg::thr_t exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
			thr_errors++;
		end
	endtask

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[30:16]) % n;
	endfunction

	// Step across the edge, per-sample noise and an optional kick on one tap
	function automatic dbf_pkg::edge_px_t make_edge(input int base, input int step,
			input int noise, input int kick_idx, input int kick);
		dbf_pkg::edge_px_t px;
		int v;
		for (int k = 0; k < `DBF_LINES; k++) begin
			for (int t = 0; t < `DBF_TAPS; t++) begin
				v = base + ((t >= 4) ? step : 0);
				if (noise > 0) begin
					v = v + rand_below(noise + 1);
				end
				if (t == kick_idx) begin
					v = v + kick;
				end
				v = (v > 255) ? 255 : v;
				px[k*LW + t*PW +: PW] = dbf_pkg::pix_t'(v);
			end
		end
		return px;
	endfunction

	// ********************************************************************
	// Reference model
	// ********************************************************************
	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int clip_int(input int lo, input int hi, input int v);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic dbf_pkg::pix_t clip_pix(input int v);
		return dbf_pkg::pix_t'(clip_int(0, 255, v));
	endfunction

	function automatic dbf_pkg::bs_t ref_bs();
		int dx;
		int dy;
		dx = int'($signed(mv_p_i[MW-1:0])) - int'($signed(mv_q_i[MW-1:0]));
		dy = int'($signed(mv_p_i[2*MW-1 -: MW])) - int'($signed(mv_q_i[2*MW-1 -: MW]));
		if ((intra_p_i || intra_q_i) && mb_edge_i) begin
			return 3'd4;
		end
		if (intra_p_i || intra_q_i) begin
			return 3'd3;
		end
		if (nz_p_i || nz_q_i) begin
			return 3'd2;
		end
		if (abs_int(dx) >= `DBF_MV_THRESH || abs_int(dy) >= `DBF_MV_THRESH) begin
			return 3'd1;
		end
		return 3'd0;
	endfunction

	function automatic logic [LW-1:0] ref_line(input logic [LW-1:0] ln, input int bs,
			input int alpha, input int beta, input int tc0);
		int s [0:7];
		int p3, p2, p1, p0, q0, q1, q2, q3;
		int tc, delta, avg;
		logic ap, aq, small_step;
		logic [LW-1:0] res;
		for (int t = 0; t < `DBF_TAPS; t++) begin
			s[t] = int'(ln[t*PW +: PW]);
		end
		p3 = s[0];
		p2 = s[1];
		p1 = s[2];
		p0 = s[3];
		q0 = s[4];
		q1 = s[5];
		q2 = s[6];
		q3 = s[7];
		res = ln;
		if (bs == 0 || abs_int(p0 - q0) >= alpha || abs_int(p1 - p0) >= beta
				|| abs_int(q1 - q0) >= beta) begin
			return ln;
		end
		ap = abs_int(p2 - p0) < beta;
		aq = abs_int(q2 - q0) < beta;
		if (bs < 4) begin
			tc = tc0 + (ap ? 1 : 0) + (aq ? 1 : 0);
			delta = clip_int(-tc, tc, (4 * (q0 - p0) + (p1 - q1) + 4) >>> 3);
			avg = (p0 + q0 + 1) >>> 1;
			res[3*PW +: PW] = clip_pix(p0 + delta);
			res[4*PW +: PW] = clip_pix(q0 - delta);
			if (ap) begin
				res[2*PW +: PW] = clip_pix(p1 + clip_int(-tc0, tc0, (p2 + avg - 2 * p1) >>> 1));
			end
			if (aq) begin
				res[5*PW +: PW] = clip_pix(q1 + clip_int(-tc0, tc0, (q2 + avg - 2 * q1) >>> 1));
			end
		end else begin
			small_step = abs_int(p0 - q0) < (alpha / 4 + 2);
			if (ap && small_step) begin
				res[3*PW +: PW] = clip_pix((p2 + 2 * p1 + 2 * p0 + 2 * q0 + q1 + 4) / 8);
				res[2*PW +: PW] = clip_pix((p2 + p1 + p0 + q0 + 2) / 4);
				res[1*PW +: PW] = clip_pix((2 * p3 + 3 * p2 + p1 + p0 + q0 + 4) / 8);
			end else begin
				res[3*PW +: PW] = clip_pix((2 * p1 + p0 + q1 + 2) / 4);
			end
			if (aq && small_step) begin
				res[4*PW +: PW] = clip_pix((p1 + 2 * p0 + 2 * q0 + 2 * q1 + q2 + 4) / 8);
				res[5*PW +: PW] = clip_pix((p0 + q0 + q1 + q2 + 2) / 4);
				res[6*PW +: PW] = clip_pix((2 * q3 + 3 * q2 + q1 + q0 + p0 + 4) / 8);
			end else begin
				res[4*PW +: PW] = clip_pix((2 * q1 + q0 + p1 + 2) / 4);
			end
		end
		return res;
	endfunction

	function automatic dbf_pkg::edge_px_t ref_edge(input dbf_pkg::edge_px_t px,
			input dbf_pkg::bs_t bs, input dbf_pkg::qp_t qp);
		dbf_pkg::edge_px_t res;
		int alpha, beta, tc0;
		alpha = int'(dbf_pkg::alpha_of(qp));
		beta = int'(dbf_pkg::beta_of(qp));
		tc0 = (bs >= 1 && bs <= 3) ? int'(dbf_pkg::tc0_of(qp, bs)) : 0;
		for (int k = 0; k < `DBF_LINES; k++) begin
			res[k*LW +: LW] = ref_line(px[k*LW +: LW], int'(bs), alpha, beta, tc0);
		end
		return res;
	endfunction

	// ********************************************************************
	// Handshake drivers
	// ********************************************************************
	task automatic wait_in_ack(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			#2;
			cycles++;
		end while (in_ack_o !== level && cycles < HS_TIMEOUT);
		if (in_ack_o !== level) begin
			$display("Timeout at %0t: in_ack_o did not reach %0b", $time, level);
			proto_errors++;
		end
	endtask

	task automatic wait_out_req(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			#2;
			cycles++;
		end while (out_req_o !== level && cycles < HS_TIMEOUT);
		if (out_req_o !== level) begin
			$display("Timeout at %0t: out_req_o did not reach %0b", $time, level);
			proto_errors++;
		end
	endtask

	task automatic set_side(input logic ip, input logic iq, input logic np, input logic nq,
			input dbf_pkg::mv_t mvp, input dbf_pkg::mv_t mvq, input logic mb);
		@(posedge clk);
		#2;
		intra_p_i = ip;
		intra_q_i = iq;
		nz_p_i = np;
		nz_q_i = nq;
		mv_p_i = mvp;
		mv_q_i = mvq;
		mb_edge_i = mb;
	endtask

	task automatic start_send(input dbf_pkg::qp_t qp, input dbf_pkg::edge_px_t px);
		@(posedge clk);
		#2;
		qp_i = qp;
		px_i = px;
		in_req_i = 1'b1;
	endtask

	task automatic finish_send();
		wait_in_ack(1'b1);
		in_req_i = 1'b0;
		wait_in_ack(1'b0);
	endtask

	// Consumer side, holding ack back for a few cycles when asked
	task automatic receive_check(input int hold);
		dbf_pkg::edge_px_t exp_px;
		dbf_pkg::bs_t      exp_bs;
		wait_out_req(1'b1);
		repeat (hold) begin
			@(posedge clk);
			#2;
		end
		exp_px = exp_px_q.pop_front();
		exp_bs = exp_bs_q.pop_front();
		check_px(out_px_o, exp_px, "filtered edge");
		check_bs(out_bs_o, exp_bs, "boundary strength");
		out_ack_i = 1'b1;
		wait_out_req(1'b0);
		out_ack_i = 1'b0;
	endtask

	task automatic run_job(input dbf_pkg::qp_t qp, input dbf_pkg::edge_px_t px,
			input dbf_pkg::edge_px_t exp_px, input dbf_pkg::bs_t exp_bs);
		exp_px_q.push_back(exp_px);
		exp_bs_q.push_back(exp_bs);
		start_send(qp, px);
		finish_send();
		receive_check(0);
	endtask

	// ********************************************************************
	// Directed tests
	// ********************************************************************
	task automatic test_reset_tables();
		@(posedge clk);
		#2;
		if (in_ack_o !== 1'b0 || out_req_o !== 1'b0) begin
			$display("in_ack_o or out_req_o is not low after reset");
			proto_errors++;
		end
		check_thr(dbf_pkg::alpha_of(6'd51), 8'd255, "alpha_of(51)");
		check_thr(dbf_pkg::beta_of(6'd51), 8'd18, "beta_of(51)");
		check_thr(dbf_pkg::alpha_of(6'd15), 8'd0, "alpha_of(15)");
	endtask

	// Flat samples pass through any filter unchanged
	task automatic test_bs_rules();
		dbf_pkg::edge_px_t flat;
		flat = {(`DBF_LINES * `DBF_TAPS){8'h80}};
		set_side(1, 0, 0, 0, 16'h0000, 16'h0000, 1);
		run_job(6'd30, flat, flat, 3'd4);
		set_side(0, 1, 0, 0, 16'h0000, 16'h0000, 0);
		run_job(6'd30, flat, flat, 3'd3);
		set_side(1'b0, 1'b0, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0);
		run_job(6'd30, flat, flat, 3'd2);
		set_side(0, 0, 0, 0, 16'h0200, 16'hFE00, 0);
		run_job(6'd30, flat, flat, 3'd1);
		set_side(0, 0, 0, 0, 16'h00FF, 16'h0002, 0);
		run_job(6'd30, flat, flat, 3'd0);
		set_side(0, 0, 0, 0, 16'h0000, 16'h0000, 1);
		run_job(6'd30, flat, flat, 3'd0);
	endtask

	task automatic test_normal();
		int qps [0:3];
		dbf_pkg::edge_px_t px;
		dbf_pkg::qp_t qp;
		qps = '{24, 32, 40, 48};
		for (int i = 0; i < 12; i++) begin
			case (i % 3)
				0: set_side(0, 0, 0, 0, 16'h0008, 16'h0000, 0);
				1: set_side(0, 0, 0, 1, 16'h0000, 16'h0000, 0);
				default: set_side(1, 0, 0, 0, 16'h0000, 16'h0000, 0);
			endcase
			qp = dbf_pkg::qp_t'(qps[i % 4]);
			px = make_edge(40 + rand_below(150), rand_below(10), 3, -1, 0);
			run_job(qp, px, ref_edge(px, ref_bs(), qp), ref_bs());
		end
	endtask

	// Both sides smoothed, both p0/q0 only, then one side each
	task automatic test_strong();
		dbf_pkg::edge_px_t px;
		int base;
		set_side(0, 1, 0, 0, 16'h0000, 16'h0000, 1);
		for (int i = 0; i < 8; i++) begin
			base = 40 + rand_below(100);
			case (i % 4)
				0: px = make_edge(base, 4, 3, -1, 0);
				1: px = make_edge(base, 30, 3, -1, 0);
				2: px = make_edge(base, 4, 3, 1, 20);
				default: px = make_edge(base, 4, 3, 6, 20);
			endcase
			run_job(6'd40, px, ref_edge(px, ref_bs(), 6'd40), ref_bs());
		end
	endtask

	task automatic test_no_filter();
		dbf_pkg::edge_px_t px;
		int alpha;
		int beta;
		alpha = int'(dbf_pkg::alpha_of(6'd40));
		beta = int'(dbf_pkg::beta_of(6'd40));
		set_side(0, 0, 0, 0, 16'h0000, 16'h0000, 0);
		for (int i = 0; i < 2; i++) begin
			px = make_edge(40 + rand_below(150), 6, 3, -1, 0);
			run_job(6'd40, px, px, ref_bs());
		end
		set_side(1, 0, 0, 0, 16'h0000, 16'h0000, 0);
		px = make_edge(40 + rand_below(60), alpha, 0, -1, 0);
		run_job(6'd40, px, px, ref_bs());
		set_side(0, 0, 1, 0, 16'h0000, 16'h0000, 0);
		px = make_edge(40 + rand_below(100), 4, 0, 2, beta);
		run_job(6'd40, px, px, ref_bs());
		set_side(0, 0, 0, 0, 16'h0010, 16'h0000, 0);
		px = make_edge(40 + rand_below(100), 4, 0, 5, beta);
		run_job(6'd40, px, px, ref_bs());
		set_side(1, 1, 0, 0, 16'h0000, 16'h0000, 1);
		px = make_edge(40 + rand_below(60), alpha, 0, -1, 0);
		run_job(6'd40, px, px, ref_bs());
	endtask

	// Three jobs fill the stages, the fourth must wait for the consumer
	task automatic test_back_pressure();
		dbf_pkg::edge_px_t px;
		logic ack_seen;
		logic req_seen;
		set_side(0, 0, 1, 0, 16'h0000, 16'h0000, 0);
		for (int i = 0; i < 3; i++) begin
			px = make_edge(40 + rand_below(150), rand_below(8), 3, -1, 0);
			exp_px_q.push_back(ref_edge(px, ref_bs(), 6'd36));
			exp_bs_q.push_back(ref_bs());
			start_send(6'd36, px);
			finish_send();
		end
		px = make_edge(40 + rand_below(150), rand_below(8), 3, -1, 0);
		exp_px_q.push_back(ref_edge(px, ref_bs(), 6'd36));
		exp_bs_q.push_back(ref_bs());
		start_send(6'd36, px);
		ack_seen = 1'b0;
		repeat (12) begin
			@(posedge clk);
			#2;
			ack_seen = ack_seen | in_ack_o;
		end
		if (ack_seen) begin
			$display("in_ack_o rose at %0t while the pipeline was full", $time);
			proto_errors++;
		end
		fork
			finish_send();
			repeat (4) receive_check(3);
		join
		// All four jobs are read back, the output must now stay quiet
		req_seen = 1'b0;
		repeat (8) begin
			@(posedge clk);
			#2;
			req_seen = req_seen | out_req_o;
		end
		if (req_seen) begin
			$display("Extra result offered at %0t after the last job was read", $time);
			proto_errors++;
		end
	endtask

	// ********************************************************************
	// Main sequence and watchdog
	// ********************************************************************
	initial begin
		clk = 1'b0;
		rst = 1'b0;
		in_req_i = 1'b0;
		qp_i = '0;
		intra_p_i = 1'b0;
		intra_q_i = 1'b0;
		nz_p_i = 1'b0;
		nz_q_i = 1'b0;
		mv_p_i = '0;
		mv_q_i = '0;
		mb_edge_i = 1'b0;
		px_i = '0;
		out_ack_i = 1'b0;
		lcg_state = 32'h2035_87ff;
		px_errors = 0;
		bs_errors = 0;
		thr_errors = 0;
		proto_errors = 0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b1;
		test_reset_tables();
		test_bs_rules();
		test_normal();
		test_strong();
		test_no_filter();
		test_back_pressure();
		$display("Errors: pixel %0d, bs %0d, table %0d, protocol %0d",
			px_errors, bs_errors, thr_errors, proto_errors);
		if (px_errors + bs_errors + thr_errors + proto_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+src
src/dbf_pkg.sv
src/dbf_bs_decode.sv
src/dbf_edge_filter.sv
src/dbf_result_hold.sv
src/dbf_top.sv
sim/dbf_tb.sv

// ==== Makefile ====
# Verilator flow for the luma deblocking edge engine

TOP = dbf_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module dbf_top
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
